//--- hw/ara_pkg.sv
// Shared widths, opcode enum and packed request, response and lane structs
`default_nettype none

package ara_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 32;
  localparam int unsigned NrVInsn   = 4;
  // Largest VLEN in bits, sizes the vl field
  localparam int unsigned MaxVLen   = 2048;

  typedef logic [ElemWidth-1:0]                     elem_t;
  typedef logic [4:0]                               vreg_idx_t;
  typedef logic [$clog2(NrVInsn)-1:0]               vinsn_id_t;
  typedef logic [$clog2(MaxVLen / ElemWidth):0]     vl_t;

  typedef enum logic [3:0] {
    VADD_VV,
    VSUB_VV,
    VAND_VV,
    VOR_VV,
    VXOR_VV,
    VADD_VX,
    VMV_V_X,
    VID_V,
    VMV_X_S,
    VREDSUM_VS
  } ara_op_e;

  //////////////////////////////
  // Interfaces
  //////////////////////////////

  // Request from the scalar core
  typedef struct packed {
    logic      valid;
    ara_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    vl_t       vl;
  } acc_req_t;

  typedef struct packed {
    logic  valid;
    elem_t result;
    logic  error;
  } acc_resp_t;

  // Decoded instruction, dispatcher to sequencer
  typedef struct packed {
    ara_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    vl_t       vl;
    logic      use_vs1;
    logic      use_vs2;
    logic      use_vd;
    logic      scalar_result;
  } ara_req_t;

  // Broadcast to the lanes, tagged with its scoreboard slot
  typedef struct packed {
    vinsn_id_t id;
    ara_req_t  req;
  } pe_req_t;

  typedef struct packed {
    logic  valid;
    elem_t value;
  } lane_scalar_t;

endpackage : ara_pkg

`default_nettype wire

//--- hw/lane_valu.sv
// Lane element ALU with the per-lane reduction accumulator
`timescale 1ns/1ps
`default_nettype none

module lane_valu import ara_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  ara_op_e      op_i,
  input  elem_t        a_i,
  input  elem_t        b_i,
  input  elem_t        scalar_i,
  input  vl_t          elem_idx_i,
  input  logic         valid_i,
  input  logic         first_i,
  input  logic         last_i,
  output elem_t        result_o,
  output lane_scalar_t scalar_o
);

  elem_t acc_q, acc_base, acc_d;
  logic  is_scalar_op;

  assign is_scalar_op = (op_i == VREDSUM_VS) || (op_i == VMV_X_S);

  // a_i is the vs1 element, b_i the vs2 element
  always_comb begin
    unique case (op_i)
      VADD_VV: result_o = b_i + a_i;
      VSUB_VV: result_o = b_i - a_i;
      VAND_VV: result_o = b_i & a_i;
      VOR_VV:  result_o = b_i | a_i;
      VXOR_VV: result_o = b_i ^ a_i;
      VADD_VX: result_o = b_i + scalar_i;
      VMV_V_X: result_o = scalar_i;
      VID_V:   result_o = elem_t'(elem_idx_i);
      default: result_o = '0;
    endcase
  end

  // Lane 0 is the one whose first position is global element 0
  always_comb begin
    acc_base = first_i ? '0 : acc_q;
    if (op_i == VREDSUM_VS) begin
      if (first_i && elem_idx_i == '0) begin
        acc_base = scalar_i;
      end
      acc_d = valid_i ? acc_base + b_i : acc_base;
    end else begin
      acc_d = (valid_i && elem_idx_i == '0) ? b_i : acc_base;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scalar_o <= '0;
    end else begin
      scalar_o.valid <= last_i && is_scalar_op;
      scalar_o.value <= acc_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (is_scalar_op) begin
      acc_q <= acc_d;
    end
  end

endmodule : lane_valu

`default_nettype wire

//--- hw/lane.sv
// Vector lane: instruction queue, register file slice and two-stage element pipeline
`timescale 1ns/1ps
`default_nettype none

module lane import ara_pkg::*; #(
  parameter  int unsigned NrLanes     = 4,
  parameter  int unsigned VLEN        = 256,
  localparam int unsigned LaneIdWidth = (NrLanes > 1) ? $clog2(NrLanes) : 1
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic [LaneIdWidth-1:0] lane_id_i,
  // Sequencer side
  input  pe_req_t                pe_req_i,
  input  logic                   pe_req_valid_i,
  output logic                   pe_req_ready_o,
  output logic [NrVInsn-1:0]     vinsn_done_o,
  // Reduction unit
  output lane_scalar_t           lane_scalar_o
);

  localparam int unsigned ElemsPerLane = VLEN / (ElemWidth * NrLanes);
  localparam int unsigned PosWidth     = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1;

  typedef logic [PosWidth-1:0] pos_t;

  // Element i of a register sits at position i / NrLanes of lane i % NrLanes
  elem_t vrf_q [NrVRegs][ElemsPerLane];

  //////////////////////////////
  // Instruction queue
  //////////////////////////////

  pe_req_t    queue_q [2];
  logic       wr_ptr_q, rd_ptr_q;
  logic [1:0] cnt_q;
  logic       push, pop;
  pe_req_t    head;

  assign head           = queue_q[rd_ptr_q];
  assign pe_req_ready_o = (cnt_q != 2'd2);
  assign push           = pe_req_valid_i && pe_req_ready_o;

  //////////////////////////////
  // Read stage
  //////////////////////////////

  pos_t pos_q;
  vl_t  vl_eff, nr_elems, elem_idx;
  logic issue, is_elem, is_last;

  always_comb begin
    // Element 0 is read whatever vl says
    vl_eff   = (head.req.op == VMV_X_S) ? vl_t'(1) : head.req.vl;
    nr_elems = '0;
    if (vl_eff > vl_t'(lane_id_i)) begin
      nr_elems = vl_t'((vl_eff - vl_t'(lane_id_i) + vl_t'(NrLanes - 1)) / NrLanes);
    end
    issue    = (cnt_q != 2'd0);
    is_elem  = vl_t'(pos_q) < nr_elems;
    // A lane without elements still runs one empty slot
    is_last  = (nr_elems == '0) || (vl_t'(pos_q) == nr_elems - 1'b1);
    elem_idx = vl_t'(pos_q) * vl_t'(NrLanes) + vl_t'(lane_id_i);
  end

  assign pop = issue && is_last;

  //////////////////////////////
  // Execute and write stage
  //////////////////////////////

  logic      s2_elem_q, s2_first_q, s2_last_q;
  logic      s2_use_vd_q;
  ara_op_e   s2_op_q;
  vinsn_id_t s2_id_q;
  vreg_idx_t s2_vd_q;
  pos_t      s2_pos_q;
  vl_t       s2_idx_q;
  elem_t     s2_a_q, s2_b_q, s2_scalar_q;
  elem_t     valu_result;

  lane_valu i_lane_valu (
    .clk_i     (clk_i        ),
    .arst_n_i  (arst_n_i     ),
    .op_i      (s2_op_q      ),
    .a_i       (s2_a_q       ),
    .b_i       (s2_b_q       ),
    .scalar_i  (s2_scalar_q  ),
    .elem_idx_i(s2_idx_q     ),
    .valid_i   (s2_elem_q    ),
    .first_i   (s2_first_q   ),
    .last_i    (s2_last_q    ),
    .result_o  (valu_result  ),
    .scalar_o  (lane_scalar_o)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q     <= 1'b0;
      rd_ptr_q     <= 1'b0;
      cnt_q        <= '0;
      pos_q        <= '0;
      s2_elem_q    <= 1'b0;
      s2_first_q   <= 1'b0;
      s2_last_q    <= 1'b0;
      vinsn_done_o <= '0;
      vrf_q        <= '{default: '0};
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      cnt_q <= cnt_q + {1'b0, push} - {1'b0, pop};
      if (issue) begin
        pos_q <= is_last ? '0 : pos_q + 1'b1;
      end
      s2_elem_q  <= issue && is_elem;
      s2_first_q <= issue && (pos_q == '0);
      s2_last_q  <= pop;
      // Done one cycle after the last write
      vinsn_done_o <= '0;
      if (s2_last_q) begin
        vinsn_done_o[s2_id_q] <= 1'b1;
      end
      if (s2_elem_q && s2_use_vd_q) begin
        vrf_q[s2_vd_q][s2_pos_q] <= valu_result;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= pe_req_i;
    end
    if (issue) begin
      s2_op_q     <= head.req.op;
      s2_id_q     <= head.id;
      s2_vd_q     <= head.req.vd;
      s2_use_vd_q <= head.req.use_vd;
      s2_scalar_q <= head.req.scalar;
      s2_pos_q    <= pos_q;
      s2_idx_q    <= elem_idx;
      s2_a_q      <= vrf_q[head.req.vs1][pos_q];
      s2_b_q      <= vrf_q[head.req.vs2][pos_q];
    end
  end

endmodule : lane

`default_nettype wire

//--- hw/ara_dispatcher.sv
// Dispatcher: core request acceptance, decode, vl check and response sequencing
`timescale 1ns/1ps
`default_nettype none

module ara_dispatcher import ara_pkg::*; #(
  parameter int unsigned VLEN = 256
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Scalar core side
  input  acc_req_t  acc_req_i,
  output logic      acc_ready_o,
  output acc_resp_t acc_resp_o,
  // Sequencer side
  output ara_req_t  ara_req_o,
  output logic      ara_req_valid_o,
  input  logic      ara_req_ready_i,
  // Reduction unit
  input  elem_t     red_result_i,
  input  logic      red_result_valid_i
);

  localparam int unsigned VLMax = VLEN / ElemWidth;

  typedef enum logic [1:0] {
    IDLE,
    FORWARD,
    WAIT_SCALAR,
    ERROR
  } state_e;

  state_e    state_q, state_d;
  ara_req_t  req_q, req_d;
  ara_req_t  dec_req;
  acc_resp_t resp_q, resp_d;

  assign ara_req_o  = req_q;
  assign acc_resp_o = resp_q;

  // Operand usage and result kind per opcode
  always_comb begin
    dec_req        = '0;
    dec_req.op     = acc_req_i.op;
    dec_req.vd     = acc_req_i.vd;
    dec_req.vs1    = acc_req_i.vs1;
    dec_req.vs2    = acc_req_i.vs2;
    dec_req.scalar = acc_req_i.scalar;
    dec_req.vl     = acc_req_i.vl;
    unique case (acc_req_i.op)
      VADD_VV, VSUB_VV, VAND_VV, VOR_VV, VXOR_VV: begin
        dec_req.use_vs1 = 1'b1;
        dec_req.use_vs2 = 1'b1;
        dec_req.use_vd  = 1'b1;
      end
      VADD_VX: begin
        dec_req.use_vs2 = 1'b1;
        dec_req.use_vd  = 1'b1;
      end
      VMV_V_X, VID_V: dec_req.use_vd = 1'b1;
      VMV_X_S, VREDSUM_VS: begin
        dec_req.use_vs2       = 1'b1;
        dec_req.scalar_result = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    state_d         = state_q;
    req_d           = req_q;
    resp_d          = '0;
    acc_ready_o     = 1'b0;
    ara_req_valid_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        acc_ready_o = 1'b1;
        if (acc_req_i.valid) begin
          if (acc_req_i.vl > vl_t'(VLMax)) begin
            resp_d.valid = 1'b1;
            resp_d.error = 1'b1;
            state_d      = ERROR;
          end else begin
            req_d   = dec_req;
            state_d = FORWARD;
          end
        end
      end
      FORWARD: begin
        ara_req_valid_o = 1'b1;
        if (ara_req_ready_i) begin
          if (req_q.scalar_result) begin
            state_d = WAIT_SCALAR;
          end else begin
            resp_d.valid = 1'b1;
            state_d      = IDLE;
          end
        end
      end
      WAIT_SCALAR: begin
        if (red_result_valid_i) begin
          resp_d.valid  = 1'b1;
          resp_d.result = red_result_i;
          state_d       = IDLE;
        end
      end
      // Error response leaves this cycle
      ERROR:   state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      resp_q  <= '0;
    end else begin
      state_q <= state_d;
      resp_q  <= resp_d;
    end
  end

  always_ff @(posedge clk_i) begin
    req_q <= req_d;
  end

endmodule : ara_dispatcher

`default_nettype wire

//--- hw/ara_sequencer.sv
// Sequencer: instruction scoreboard, hazard stall and broadcast to the lanes
`timescale 1ns/1ps
`default_nettype none

module ara_sequencer import ara_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  // Dispatcher side
  input  ara_req_t                        ara_req_i,
  input  logic                            ara_req_valid_i,
  output logic                            ara_req_ready_o,
  // Lane side
  output pe_req_t                         pe_req_o,
  output logic                            pe_req_valid_o,
  input  logic [NrLanes-1:0]              pe_req_ready_i,
  input  logic [NrLanes-1:0][NrVInsn-1:0] vinsn_done_i
);

  // Scoreboard slots, one per instruction id
  logic      [NrVInsn-1:0]              busy_q;
  logic      [NrVInsn-1:0]              writes_q;
  vreg_idx_t [NrVInsn-1:0]              vd_q;
  logic      [NrVInsn-1:0][NrLanes-1:0] done_mask_q, done_mask_d;

  pe_req_t   pe_req_q;
  logic      pe_valid_q;

  logic      hazard;
  logic      free_found;
  vinsn_id_t free_id;
  logic      accept;
  logic      broadcast;

  // RAW and WAW check against busy slots, lowest free slot
  always_comb begin
    hazard     = 1'b0;
    free_found = 1'b0;
    free_id    = '0;
    for (int i = 0; i < NrVInsn; i++) begin
      if (busy_q[i] && writes_q[i]) begin
        if ((ara_req_i.use_vs1 && ara_req_i.vs1 == vd_q[i]) ||
            (ara_req_i.use_vs2 && ara_req_i.vs2 == vd_q[i]) ||
            (ara_req_i.use_vd  && ara_req_i.vd  == vd_q[i])) begin
          hazard = 1'b1;
        end
      end
      if (!busy_q[i] && !free_found) begin
        free_found = 1'b1;
        free_id    = vinsn_id_t'(i);
      end
    end
  end

  // Done pulses of this cycle merged in
  always_comb begin
    for (int i = 0; i < NrVInsn; i++) begin
      for (int l = 0; l < NrLanes; l++) begin
        done_mask_d[i][l] = done_mask_q[i][l] | vinsn_done_i[l][i];
      end
    end
  end

  assign ara_req_ready_o = !pe_valid_q && free_found && !hazard;
  assign accept          = ara_req_valid_i && ara_req_ready_o;
  // Every lane has to take the broadcast in the same cycle
  assign broadcast       = pe_valid_q && (&pe_req_ready_i);

  assign pe_req_o        = pe_req_q;
  assign pe_req_valid_o  = pe_valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= '0;
      done_mask_q <= '0;
      pe_valid_q  <= 1'b0;
    end else begin
      done_mask_q <= done_mask_d;
      for (int i = 0; i < NrVInsn; i++) begin
        if (busy_q[i] && (&done_mask_d[i])) begin
          busy_q[i] <= 1'b0;
        end
      end
      if (broadcast) begin
        pe_valid_q <= 1'b0;
      end
      if (accept) begin
        busy_q[free_id]      <= 1'b1;
        done_mask_q[free_id] <= '0;
        pe_valid_q           <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      writes_q[free_id] <= ara_req_i.use_vd;
      vd_q[free_id]     <= ara_req_i.vd;
      pe_req_q.id       <= free_id;
      pe_req_q.req      <= ara_req_i;
    end
  end

endmodule : ara_sequencer

`default_nettype wire

//--- hw/ara_red_unit.sv
// Reduction unit: collects and sums the per-lane scalar contributions
`timescale 1ns/1ps
`default_nettype none

module ara_red_unit import ara_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  lane_scalar_t [NrLanes-1:0] lane_scalar_i,
  output elem_t                      red_result_o,
  output logic                       red_result_valid_o
);

  // Lanes finish at different cycles, so each one is held until all arrived
  logic  [NrLanes-1:0] got_q, got_d;
  elem_t [NrLanes-1:0] part_q, part_d;
  elem_t               sum;
  logic                all_in;

  always_comb begin
    sum = '0;
    for (int l = 0; l < NrLanes; l++) begin
      got_d[l]  = got_q[l] | lane_scalar_i[l].valid;
      part_d[l] = lane_scalar_i[l].valid ? lane_scalar_i[l].value : part_q[l];
      sum       = sum + part_d[l];
    end
  end

  assign all_in = &got_d;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      got_q              <= '0;
      red_result_valid_o <= 1'b0;
    end else begin
      got_q              <= all_in ? '0 : got_d;
      red_result_valid_o <= all_in;
    end
  end

  always_ff @(posedge clk_i) begin
    part_q <= part_d;
    if (all_in) begin
      red_result_o <= sum;
    end
  end

endmodule : ara_red_unit

`default_nettype wire

//--- hw/ara.sv
// Vector coprocessor top level: dispatcher, sequencer, lanes and reduction unit
`timescale 1ns/1ps
`default_nettype none

module ara import ara_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 256
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  acc_req_t  acc_req_i,
  output logic      acc_ready_o,
  output acc_resp_t acc_resp_o
);

  localparam int unsigned LaneIdWidth = (NrLanes > 1) ? $clog2(NrLanes) : 1;

  //////////////////////////////
  // Dispatcher
  //////////////////////////////

  ara_req_t ara_req;
  logic     ara_req_valid;
  logic     ara_req_ready;
  elem_t    red_result;
  logic     red_result_valid;

  ara_dispatcher #(
    .VLEN(VLEN)
  ) i_dispatcher (
    .clk_i             (clk_i           ),
    .arst_n_i          (arst_n_i        ),
    .acc_req_i         (acc_req_i       ),
    .acc_ready_o       (acc_ready_o     ),
    .acc_resp_o        (acc_resp_o      ),
    .ara_req_o         (ara_req         ),
    .ara_req_valid_o   (ara_req_valid   ),
    .ara_req_ready_i   (ara_req_ready   ),
    .red_result_i      (red_result      ),
    .red_result_valid_i(red_result_valid)
  );

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  pe_req_t                         pe_req;
  logic                            pe_req_valid;
  logic [NrLanes-1:0]              pe_req_ready;
  logic                            pe_req_fire;
  logic [NrLanes-1:0][NrVInsn-1:0] vinsn_done;

  ara_sequencer #(
    .NrLanes(NrLanes)
  ) i_sequencer (
    .clk_i          (clk_i        ),
    .arst_n_i       (arst_n_i     ),
    .ara_req_i      (ara_req      ),
    .ara_req_valid_i(ara_req_valid),
    .ara_req_ready_o(ara_req_ready),
    .pe_req_o       (pe_req       ),
    .pe_req_valid_o (pe_req_valid ),
    .pe_req_ready_i (pe_req_ready ),
    .vinsn_done_i   (vinsn_done   )
  );

  //////////////////////////////
  // Lanes
  //////////////////////////////

  // A lane queues the broadcast only when every lane takes it
  assign pe_req_fire = pe_req_valid & (&pe_req_ready);

  lane_scalar_t [NrLanes-1:0] lane_scalar;

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    lane #(
      .NrLanes(NrLanes),
      .VLEN   (VLEN   )
    ) i_lane (
      .clk_i         (clk_i               ),
      .arst_n_i      (arst_n_i            ),
      .lane_id_i     (LaneIdWidth'(l)     ),
      .pe_req_i      (pe_req              ),
      .pe_req_valid_i(pe_req_fire         ),
      .pe_req_ready_o(pe_req_ready[l]     ),
      .vinsn_done_o  (vinsn_done[l]       ),
      .lane_scalar_o (lane_scalar[l]      )
    );
  end : gen_lanes

  ara_red_unit #(
    .NrLanes(NrLanes)
  ) i_red_unit (
    .clk_i             (clk_i           ),
    .arst_n_i          (arst_n_i        ),
    .lane_scalar_i     (lane_scalar     ),
    .red_result_o      (red_result      ),
    .red_result_valid_o(red_result_valid)
  );

endmodule : ara

`default_nettype wire

//--- sim/ara_tb.sv
// Testbench for the vector coprocessor: clock, reset, reference model, stimulus and checks
`timescale 1ns/1ps
`default_nettype none

module ara_tb import ara_pkg::*; ();

  localparam int unsigned NrLanes = 4;
  localparam int unsigned VLEN    = 256;
  localparam int unsigned VLMax   = VLEN / ElemWidth;

  // Test sizes
  localparam int NumVid     = 4;
  localparam int NumRand    = 24;
  localparam int NumIllegal = 3;
  localparam int NumChains  = 6;
  localparam int NrInsn     = 3 * NumVid + 3 * NumRand + 2 * NumIllegal + 5 * NumChains + 4;
  localparam int TimeoutCycles = 20 * NrInsn * (VLMax / NrLanes + 8);
  localparam int DrainLimit    = 1000;

  logic      clk_i;
  logic      arst_n_i;
  acc_req_t  acc_req;
  logic      acc_ready_o;
  acc_resp_t acc_resp_o;

  // Reference register file, element i of register r at [r][i]
  elem_t     vrf_model [NrVRegs][VLMax];
  acc_resp_t exp_q [$];
  int        cycle_cnt = 0;

  ara #(
    .NrLanes(NrLanes),
    .VLEN   (VLEN   )
  ) ara_i (
    .clk_i      (clk_i      ),
    .arst_n_i   (arst_n_i   ),
    .acc_req_i  (acc_req    ),
    .acc_ready_o(acc_ready_o),
    .acc_resp_o (acc_resp_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Failure reporting
  //////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("[ERROR] %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp_v, act_v);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Applies one legal instruction and returns the scalar the core gets back
  function automatic elem_t apply_model(input ara_op_e op, input int vd, input int vs1,
                                        input int vs2, input elem_t scalar, input int vl);
    elem_t acc;
    elem_t a;
    elem_t b;
    acc = scalar;
    if (op == VMV_X_S) begin
      return vrf_model[vs2][0];
    end
    if (op == VREDSUM_VS) begin
      for (int i = 0; i < vl; i++) begin
        acc = acc + vrf_model[vs2][i];
      end
      return acc;
    end
    for (int i = 0; i < vl; i++) begin
      a = vrf_model[vs1][i];
      b = vrf_model[vs2][i];
      case (op)
        VADD_VV: vrf_model[vd][i] = b + a;
        VSUB_VV: vrf_model[vd][i] = b - a;
        VAND_VV: vrf_model[vd][i] = b & a;
        VOR_VV:  vrf_model[vd][i] = b | a;
        VXOR_VV: vrf_model[vd][i] = b ^ a;
        VADD_VX: vrf_model[vd][i] = b + scalar;
        VMV_V_X: vrf_model[vd][i] = scalar;
        VID_V:   vrf_model[vd][i] = elem_t'(i);
        default: ;
      endcase
    end
    return '0;
  endfunction

  function automatic ara_op_e pick_elem_op(input int sel);
    case (sel)
      0:       return VADD_VV;
      1:       return VSUB_VV;
      2:       return VAND_VV;
      3:       return VOR_VV;
      4:       return VXOR_VV;
      5:       return VADD_VX;
      default: return VMV_V_X;
    endcase
  endfunction

  //////////////////////////////
  // Request driver
  //////////////////////////////

  // Called a little after a rising edge, returns the same way after the handshake
  task automatic issue(input ara_op_e op, input int vd, input int vs1, input int vs2,
                       input elem_t scalar, input int vl);
    acc_resp_t expected;
    expected       = '0;
    expected.valid = 1'b1;
    acc_req.valid  = 1'b1;
    acc_req.op     = op;
    acc_req.vd     = vreg_idx_t'(vd);
    acc_req.vs1    = vreg_idx_t'(vs1);
    acc_req.vs2    = vreg_idx_t'(vs2);
    acc_req.scalar = scalar;
    acc_req.vl     = vl_t'(vl);
    if (vl > int'(VLMax)) begin
      expected.error = 1'b1;
    end else begin
      expected.result = apply_model(op, vd, vs1, vs2, scalar, vl);
    end
    exp_q.push_back(expected);
    @(negedge clk_i);
    while (!acc_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    acc_req.valid = 1'b0;
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  always @(negedge clk_i) begin : check_resp
    acc_resp_t expected;
    if (acc_resp_o.valid) begin
      assert (exp_q.size() != 0)
        else report_failure("response from the DUT with no request waiting for it");
      if (exp_q.size() != 0) begin
        expected = exp_q.pop_front();
        assert (acc_resp_o.error == expected.error)
          else report_mismatch("acc_resp_o.error", 32'(expected.error), 32'(acc_resp_o.error));
        assert (acc_resp_o.result == expected.result)
          else report_mismatch("acc_resp_o.result", expected.result, acc_resp_o.result);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    assert (cycle_cnt <= TimeoutCycles)
      else report_failure("timeout, the DUT stopped answering");
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int r;
    int q;
    int vl;
    int drain;
    void'($urandom(83));
    acc_req  = '0;
    arst_n_i = 1'b0;
    for (int i = 0; i < int'(NrVRegs); i++) begin
      for (int j = 0; j < int'(VLMax); j++) begin
        vrf_model[i][j] = '0;
      end
    end
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    assert (acc_ready_o) else report_failure("acc_ready_o is low after reset");
    @(posedge clk_i);
    #1;

    // Element index, then element 0 and sum of the indices
    for (int k = 0; k < NumVid; k++) begin
      r  = $urandom_range(0, NrVRegs - 1);
      vl = $urandom_range(0, VLMax);
      issue(VID_V, r, 0, 0, '0, vl);
      issue(VMV_X_S, 0, 0, r, '0, VLMax);
      issue(VREDSUM_VS, 0, 0, r, $urandom, vl);
    end

    // Random element-wise ops, each read back over the full register
    for (int k = 0; k < NumRand; k++) begin
      r  = $urandom_range(0, NrVRegs - 1);
      vl = $urandom_range(0, VLMax);
      issue(pick_elem_op($urandom_range(0, 6)), r, $urandom_range(0, NrVRegs - 1),
            $urandom_range(0, NrVRegs - 1), $urandom, vl);
      issue(VREDSUM_VS, 0, 0, r, $urandom, VLMax);
      issue(VMV_X_S, 0, 0, r, '0, VLMax);
    end

    // vl above the limit writes nothing
    for (int k = 0; k < NumIllegal; k++) begin
      r = $urandom_range(0, NrVRegs - 1);
      issue(VMV_V_X, r, 0, 0, $urandom, $urandom_range(VLMax + 1, 127));
      issue(VREDSUM_VS, 0, 0, r, '0, VLMax);
    end

    // Dependent chains mixed with independent writes
    for (int k = 0; k < NumChains; k++) begin
      r = $urandom_range(0, NrVRegs - 1);
      q = $urandom_range(0, NrVRegs - 1);
      issue(VADD_VX, r, 0, r, $urandom, VLMax);
      issue(VXOR_VV, r, r, q, '0, $urandom_range(0, VLMax));
      issue(VMV_V_X, $urandom_range(0, NrVRegs - 1), 0, 0, $urandom, VLMax);
      issue(VSUB_VV, r, q, r, '0, VLMax);
      issue(VREDSUM_VS, 0, 0, r, $urandom, VLMax);
    end

    // vl of zero
    r = $urandom_range(0, NrVRegs - 1);
    issue(VMV_V_X, r, 0, 0, $urandom, 0);
    issue(VADD_VV, r, r, r, '0, 0);
    issue(VREDSUM_VS, 0, 0, r, '0, VLMax);
    issue(VMV_X_S, 0, 0, r, '0, VLMax);

    // Wait for the last responses
    drain = 0;
    while (exp_q.size() != 0 && drain < DrainLimit) begin
      @(posedge clk_i);
      drain++;
    end
    if (exp_q.size() != 0) begin
      report_failure("a response never came back from the DUT");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule : ara_tb

`default_nettype wire

//--- sim.f
hw/ara_pkg.sv
hw/lane_valu.sv
hw/lane.sv
hw/ara_dispatcher.sv
hw/ara_sequencer.sv
hw/ara_red_unit.sv
hw/ara.sv
sim/ara_tb.sv

//--- Makefile
TOP := ara_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
